// ==== verilog/trav_cfg.svh ====
`ifndef TRAV_CFG_SVH
`define TRAV_CFG_SVH

// signed fixed-point coordinate width
`define COORD_W 16

// fraction bits of a coordinate and of the split parameter
`define FRAC_W 8

// signed ray parameter width
`define T_W 16

// ray store depth
`define NUM_RAYS 16

// tree node id width
`define NODE_W 8

// axis code of a leaf node
`define AXIS_LEAF 3

`endif

// ==== verilog/trav_pkg.sv ====
`include "trav_cfg.svh"

package trav_pkg;

	// position, split position or inverse direction component
	typedef logic signed [`COORD_W-1:0] coord_t;

	// ray parameter along the ray
	typedef logic signed [`T_W-1:0] tparam_t;

	// index into the ray store
	typedef logic [$clog2(`NUM_RAYS)-1:0] ray_id_t;

	// kd-tree node id
	typedef logic [`NODE_W-1:0] node_id_t;

	// 0 is x, 1 is y, 2 is z, the last code marks a leaf
	typedef logic [1:0] axis_t;

	// children to visit after the split test
	typedef enum logic [1:0] {
		visit_near = 2'd0,
		visit_far  = 2'd1,
		visit_both = 2'd2,
		visit_leaf = 2'd3
	} visit_t;

endpackage

// ==== verilog/trav_if.sv ====
`timescale 1ns/1ps

// decode to execute with the ray component already picked by the node axis
interface trav_sel_if;
	logic valid;
	logic stall;
	trav_pkg::ray_id_t ray_id;
	trav_pkg::node_id_t node_id;
	trav_pkg::axis_t axis;
	trav_pkg::coord_t split;
	trav_pkg::coord_t origin;
	trav_pkg::coord_t inv_dir;
	trav_pkg::tparam_t t_min;
	trav_pkg::tparam_t t_max;

	modport src (
		output valid, ray_id, node_id, axis, split, origin, inv_dir, t_min, t_max,
		input stall
	);

	modport dst (
		input valid, ray_id, node_id, axis, split, origin, inv_dir, t_min, t_max,
		output stall
	);
endinterface

// execute to result carrying the split parameter and direction sign
interface trav_split_if;
	logic valid;
	logic stall;
	trav_pkg::ray_id_t ray_id;
	trav_pkg::node_id_t node_id;
	trav_pkg::axis_t axis;
	logic dir_neg;
	trav_pkg::tparam_t t_split;
	trav_pkg::tparam_t t_min;
	trav_pkg::tparam_t t_max;

	modport src (
		output valid, ray_id, node_id, axis, dir_neg, t_split, t_min, t_max,
		input stall
	);

	modport dst (
		input valid, ray_id, node_id, axis, dir_neg, t_split, t_min, t_max,
		output stall
	);
endinterface

// ==== verilog/trav_decode.sv ====
`timescale 1ns/1ps
`include "trav_cfg.svh"

module trav_decode (
	input logic clk,
	input logic rst_n,
	input logic ray_we,
	input trav_pkg::ray_id_t ray_waddr,
	input trav_pkg::coord_t ray_origin_x,
	input trav_pkg::coord_t ray_origin_y,
	input trav_pkg::coord_t ray_origin_z,
	input trav_pkg::coord_t ray_inv_dir_x,
	input trav_pkg::coord_t ray_inv_dir_y,
	input trav_pkg::coord_t ray_inv_dir_z,
	input logic req_valid,
	output logic req_stall,
	input trav_pkg::ray_id_t req_ray_id,
	input trav_pkg::node_id_t req_node_id,
	input trav_pkg::axis_t req_axis,
	input trav_pkg::coord_t req_split,
	input trav_pkg::tparam_t req_t_min,
	input trav_pkg::tparam_t req_t_max,
	trav_sel_if.src sel
);

	// ray store with one array per component
	trav_pkg::coord_t origin_x_mem [`NUM_RAYS];
	trav_pkg::coord_t origin_y_mem [`NUM_RAYS];
	trav_pkg::coord_t origin_z_mem [`NUM_RAYS];
	trav_pkg::coord_t inv_dir_x_mem [`NUM_RAYS];
	trav_pkg::coord_t inv_dir_y_mem [`NUM_RAYS];
	trav_pkg::coord_t inv_dir_z_mem [`NUM_RAYS];

	// ray read out with the request
	trav_pkg::coord_t origin_x_q;
	trav_pkg::coord_t origin_y_q;
	trav_pkg::coord_t origin_z_q;
	trav_pkg::coord_t inv_dir_x_q;
	trav_pkg::coord_t inv_dir_y_q;
	trav_pkg::coord_t inv_dir_z_q;

	logic load;

	// stage is full and execute cannot take it
	assign req_stall = sel.valid && sel.stall;
	assign load = req_valid && !req_stall;

	always_ff @(posedge clk) begin
		if (ray_we) begin
			origin_x_mem[ray_waddr] <= ray_origin_x;
			origin_y_mem[ray_waddr] <= ray_origin_y;
			origin_z_mem[ray_waddr] <= ray_origin_z;
			inv_dir_x_mem[ray_waddr] <= ray_inv_dir_x;
			inv_dir_y_mem[ray_waddr] <= ray_inv_dir_y;
			inv_dir_z_mem[ray_waddr] <= ray_inv_dir_z;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sel.valid <= 1'b0;
		end else if (!req_stall) begin
			sel.valid <= req_valid;
		end
	end

	// request fields plus the stored ray held while stalled
	always_ff @(posedge clk) begin
		if (load) begin
			sel.ray_id <= req_ray_id;
			sel.node_id <= req_node_id;
			sel.axis <= req_axis;
			sel.split <= req_split;
			sel.t_min <= req_t_min;
			sel.t_max <= req_t_max;
			origin_x_q <= origin_x_mem[req_ray_id];
			origin_y_q <= origin_y_mem[req_ray_id];
			origin_z_q <= origin_z_mem[req_ray_id];
			inv_dir_x_q <= inv_dir_x_mem[req_ray_id];
			inv_dir_y_q <= inv_dir_y_mem[req_ray_id];
			inv_dir_z_q <= inv_dir_z_mem[req_ray_id];
		end
	end

	// component select where a leaf falls through to z
	always_comb begin
		case (sel.axis)
			2'd0: begin
				sel.origin = origin_x_q;
				sel.inv_dir = inv_dir_x_q;
			end
			2'd1: begin
				sel.origin = origin_y_q;
				sel.inv_dir = inv_dir_y_q;
			end
			default: begin
				sel.origin = origin_z_q;
				sel.inv_dir = inv_dir_z_q;
			end
		endcase
	end

endmodule

// ==== verilog/trav_execute.sv ====
`timescale 1ns/1ps
`include "trav_cfg.svh"

module trav_execute (
	input logic clk,
	input logic rst_n,
	trav_sel_if.dst sel,
	trav_split_if.src split
);

	// difference needs one extra bit and the product holds both operands
	localparam int PROD_W = `COORD_W + 1 + `COORD_W;
	localparam logic signed [PROD_W-1:0] T_POS = (2 ** (`T_W - 1)) - 1;
	localparam logic signed [PROD_W-1:0] T_NEG = -(2 ** (`T_W - 1));

	logic signed [`COORD_W:0] diff;
	logic signed [PROD_W-1:0] prod;
	logic signed [PROD_W-1:0] prod_sh;
	trav_pkg::tparam_t t_split_sat;
	logic load;

	assign sel.stall = split.valid && split.stall;
	assign load = sel.valid && !sel.stall;

	// t at the split plane scaled back to fixed point
	assign diff = sel.split - sel.origin;
	assign prod = diff * sel.inv_dir;
	assign prod_sh = prod >>> `FRAC_W;

	// clamp to the tparam range
	always_comb begin
		if (prod_sh > T_POS) begin
			t_split_sat = T_POS[`T_W-1:0];
		end else if (prod_sh < T_NEG) begin
			t_split_sat = T_NEG[`T_W-1:0];
		end else begin
			t_split_sat = prod_sh[`T_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			split.valid <= 1'b0;
		end else if (!sel.stall) begin
			split.valid <= sel.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			split.ray_id <= sel.ray_id;
			split.node_id <= sel.node_id;
			split.axis <= sel.axis;
			split.dir_neg <= sel.inv_dir[`COORD_W-1];
			split.t_split <= t_split_sat;
			split.t_min <= sel.t_min;
			split.t_max <= sel.t_max;
		end
	end

endmodule

// ==== verilog/trav_result.sv ====
`timescale 1ns/1ps
`include "trav_cfg.svh"

module trav_result (
	input logic clk,
	input logic rst_n,
	trav_split_if.dst split,
	output logic out_valid,
	input logic out_stall,
	output trav_pkg::ray_id_t out_ray_id,
	output trav_pkg::visit_t out_visit,
	output trav_pkg::node_id_t out_near_id,
	output trav_pkg::node_id_t out_far_id,
	output trav_pkg::tparam_t out_t_split
);

	trav_pkg::node_id_t sibling_id;
	trav_pkg::node_id_t near_id;
	trav_pkg::node_id_t far_id;
	trav_pkg::visit_t visit;
	logic load;

	assign split.stall = out_valid && out_stall;
	assign load = split.valid && !split.stall;

	// children sit next to each other, first one is below the plane
	assign sibling_id = split.node_id + trav_pkg::node_id_t'(1);
	assign near_id = split.dir_neg ? sibling_id : split.node_id;
	assign far_id = split.dir_neg ? split.node_id : sibling_id;

	always_comb begin
		if (split.axis == `AXIS_LEAF) begin
			visit = trav_pkg::visit_leaf;
		end else if (split.t_split >= split.t_max || split.t_split[`T_W-1]) begin
			// plane behind the ray or past the segment
			visit = trav_pkg::visit_near;
		end else if (split.t_split <= split.t_min) begin
			visit = trav_pkg::visit_far;
		end else begin
			visit = trav_pkg::visit_both;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (!split.stall) begin
			out_valid <= split.valid;
		end
	end

	// output holding register
	always_ff @(posedge clk) begin
		if (load) begin
			out_ray_id <= split.ray_id;
			out_visit <= visit;
			out_near_id <= near_id;
			out_far_id <= far_id;
			out_t_split <= split.t_split;
		end
	end

endmodule

// ==== verilog/raypipe_trav.sv ====
`timescale 1ns/1ps

module raypipe_trav (
	input logic clk,
	input logic rst_n,

	// ray store writes
	input logic ray_we,
	input trav_pkg::ray_id_t ray_waddr,
	input trav_pkg::coord_t ray_origin_x,
	input trav_pkg::coord_t ray_origin_y,
	input trav_pkg::coord_t ray_origin_z,
	input trav_pkg::coord_t ray_inv_dir_x,
	input trav_pkg::coord_t ray_inv_dir_y,
	input trav_pkg::coord_t ray_inv_dir_z,

	// traversal requests
	input logic req_valid,
	output logic req_stall,
	input trav_pkg::ray_id_t req_ray_id,
	input trav_pkg::node_id_t req_node_id,
	input trav_pkg::axis_t req_axis,
	input trav_pkg::coord_t req_split,
	input trav_pkg::tparam_t req_t_min,
	input trav_pkg::tparam_t req_t_max,

	// child visit results
	output logic out_valid,
	input logic out_stall,
	output trav_pkg::ray_id_t out_ray_id,
	output trav_pkg::visit_t out_visit,
	output trav_pkg::node_id_t out_near_id,
	output trav_pkg::node_id_t out_far_id,
	output trav_pkg::tparam_t out_t_split
);

	trav_sel_if sel_if ();
	trav_split_if split_if ();

	// ray store read and axis select
	trav_decode u_decode (
		.clk,
		.rst_n,
		.ray_we,
		.ray_waddr,
		.ray_origin_x,
		.ray_origin_y,
		.ray_origin_z,
		.ray_inv_dir_x,
		.ray_inv_dir_y,
		.ray_inv_dir_z,
		.req_valid,
		.req_stall,
		.req_ray_id,
		.req_node_id,
		.req_axis,
		.req_split,
		.req_t_min,
		.req_t_max,
		.sel(sel_if.src)
	);

	// split plane parameter
	trav_execute u_execute (
		.clk,
		.rst_n,
		.sel(sel_if.dst),
		.split(split_if.src)
	);

	// near and far classification
	trav_result u_result (
		.clk,
		.rst_n,
		.split(split_if.dst),
		.out_valid,
		.out_stall,
		.out_ray_id,
		.out_visit,
		.out_near_id,
		.out_far_id,
		.out_t_split
	);

endmodule

// ==== dv/trav_checker.sv ====
`timescale 1ns/1ps

module trav_checker (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic req_stall,
	input logic out_valid,
	input logic out_stall,
	input trav_pkg::ray_id_t out_ray_id,
	input trav_pkg::visit_t out_visit,
	input trav_pkg::node_id_t out_near_id,
	input trav_pkg::node_id_t out_far_id,
	input trav_pkg::tparam_t out_t_split,
	input int cycle,
	input logic check_latency,
	output int error_count,
	output int result_count
);

	// one entry per accepted request with the oldest first
	trav_pkg::ray_id_t exp_ray_q[$];
	trav_pkg::visit_t exp_visit_q[$];
	trav_pkg::node_id_t exp_near_q[$];
	trav_pkg::node_id_t exp_far_q[$];
	trav_pkg::tparam_t exp_t_q[$];
	int accept_cycle_q[$];

	// requests accepted and not yet out
	int in_flight;

	task automatic expect_result(input trav_pkg::ray_id_t ray_id, input trav_pkg::visit_t visit,
		input trav_pkg::node_id_t near_id, input trav_pkg::node_id_t far_id,
		input trav_pkg::tparam_t t_split, input int accept_cycle);
		exp_ray_q.push_back(ray_id);
		exp_visit_q.push_back(visit);
		exp_near_q.push_back(near_id);
		exp_far_q.push_back(far_id);
		exp_t_q.push_back(t_split);
		accept_cycle_q.push_back(accept_cycle);
	endtask

	task automatic compare_field(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %h got %h", name, expected, actual);
			error_count++;
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			in_flight <= 0;
		end else begin
			// stall only with all three stages full and the output held
			compare_field("req_stall", in_flight == 3 && out_stall, req_stall);
			in_flight <= in_flight + int'(req_valid && !req_stall)
				- int'(out_valid && !out_stall);
			// output transfer when valid is high and stall is low
			if (out_valid && !out_stall) begin
				if (exp_ray_q.size() == 0) begin
					$display("result for ray %h came out with no request outstanding",
						out_ray_id);
					error_count++;
				end else begin
					compare_field("out_ray_id", exp_ray_q.pop_front(), out_ray_id);
					compare_field("out_visit", exp_visit_q.pop_front(), out_visit);
					compare_field("out_near_id", exp_near_q.pop_front(), out_near_id);
					compare_field("out_far_id", exp_far_q.pop_front(), out_far_id);
					compare_field("out_t_split", exp_t_q.pop_front(), out_t_split);
					// decode, execute and result each take one cycle
					if (check_latency) begin
						compare_field("latency", 32'd3, cycle - accept_cycle_q.pop_front());
					end else begin
						void'(accept_cycle_q.pop_front());
					end
					result_count <= result_count + 1;
				end
			end
		end
	end

endmodule

// ==== dv/tb_raypipe_trav.sv ====
`timescale 1ns/1ps
`include "trav_cfg.svh"

module tb_raypipe_trav;

	// request counts of the leaf, random, directed, back-pressure, single and rewrite tests
	localparam int NUM_REQ = 16 + 200 + 6 + 150 + 20 + 6;
	localparam int CYCLE_LIMIT = NUM_REQ * 8 + 200;

	logic clk;
	logic rst_n;
	logic ray_we;
	trav_pkg::ray_id_t ray_waddr;
	trav_pkg::coord_t ray_origin_x;
	trav_pkg::coord_t ray_origin_y;
	trav_pkg::coord_t ray_origin_z;
	trav_pkg::coord_t ray_inv_dir_x;
	trav_pkg::coord_t ray_inv_dir_y;
	trav_pkg::coord_t ray_inv_dir_z;
	logic req_valid;
	logic req_stall;
	trav_pkg::ray_id_t req_ray_id;
	trav_pkg::node_id_t req_node_id;
	trav_pkg::axis_t req_axis;
	trav_pkg::coord_t req_split;
	trav_pkg::tparam_t req_t_min;
	trav_pkg::tparam_t req_t_max;
	logic out_valid;
	logic out_stall;
	trav_pkg::ray_id_t out_ray_id;
	trav_pkg::visit_t out_visit;
	trav_pkg::node_id_t out_near_id;
	trav_pkg::node_id_t out_far_id;
	trav_pkg::tparam_t out_t_split;

	int cycle = 0;
	logic check_latency;
	int error_count;
	int result_count;
	int sent_count;
	int tb_errors;
	logic [31:0] rng_state;
	logic stall_mode;
	int stall_left;

	// model ray store indexed by axis first
	trav_pkg::coord_t mdl_org [3][`NUM_RAYS];
	trav_pkg::coord_t mdl_inv [3][`NUM_RAYS];

	raypipe_trav u_raypipe_trav (.*);
	trav_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	initial begin
		while (cycle < CYCLE_LIMIT) @(posedge clk);
		$display("timeout after %0d cycles, %0d of %0d results seen", cycle, result_count,
			sent_count);
		$display("Errors found");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// expected step result from the model ray store
	function automatic void predict(input trav_pkg::ray_id_t id, input trav_pkg::node_id_t node,
		input trav_pkg::axis_t axis, input trav_pkg::coord_t split,
		input trav_pkg::tparam_t t_min, input trav_pkg::tparam_t t_max,
		output trav_pkg::visit_t visit, output trav_pkg::node_id_t near_id,
		output trav_pkg::node_id_t far_id, output trav_pkg::tparam_t t_split);
		int c;
		longint t;
		longint t_hi;
		// leaf reads the z component
		c = (axis == `AXIS_LEAF) ? 2 : int'(axis);
		t_hi = (longint'(1) <<< (`T_W - 1)) - 1;
		t = ((longint'(split) - longint'(mdl_org[c][id])) * longint'(mdl_inv[c][id])) >>> `FRAC_W;
		if (t > t_hi) begin
			t = t_hi;
		end else if (t < -t_hi - 1) begin
			t = -t_hi - 1;
		end
		t_split = trav_pkg::tparam_t'(t);
		near_id = (mdl_inv[c][id] < 0) ? trav_pkg::node_id_t'(node + 1) : node;
		far_id = (mdl_inv[c][id] < 0) ? node : trav_pkg::node_id_t'(node + 1);
		if (axis == `AXIS_LEAF) begin
			visit = trav_pkg::visit_leaf;
		end else if (t >= t_max || t < 0) begin
			visit = trav_pkg::visit_near;
		end else if (t <= t_min) begin
			visit = trav_pkg::visit_far;
		end else begin
			visit = trav_pkg::visit_both;
		end
	endfunction

	// random high and low stretches on out_stall
	task automatic update_stall();
		logic [31:0] r;
		if (!stall_mode) begin
			out_stall = 1'b0;
		end else if (stall_left > 0) begin
			stall_left--;
		end else begin
			r = next_rand();
			out_stall = r[0];
			stall_left = int'(r[3:1]);
		end
	endtask

	task automatic write_ray(input trav_pkg::ray_id_t id, input trav_pkg::coord_t ox,
		input trav_pkg::coord_t oy, input trav_pkg::coord_t oz, input trav_pkg::coord_t dx,
		input trav_pkg::coord_t dy, input trav_pkg::coord_t dz);
		@(negedge clk);
		ray_we = 1'b1;
		ray_waddr = id;
		{ray_origin_x, ray_origin_y, ray_origin_z} = {ox, oy, oz};
		{ray_inv_dir_x, ray_inv_dir_y, ray_inv_dir_z} = {dx, dy, dz};
		{mdl_org[0][id], mdl_org[1][id], mdl_org[2][id]} = {ox, oy, oz};
		{mdl_inv[0][id], mdl_inv[1][id], mdl_inv[2][id]} = {dx, dy, dz};
		@(negedge clk);
		ray_we = 1'b0;
	endtask

	task automatic write_random_ray(input trav_pkg::ray_id_t id);
		trav_pkg::coord_t v[6];
		logic [31:0] r;
		for (int k = 0; k < 6; k++) begin
			r = next_rand();
			// odd rays stay small so t_split often lands in range
			if (!id[0]) begin
				v[k] = r[15:0];
			end else if (k < 3) begin
				v[k] = trav_pkg::coord_t'($signed(r[11:0]));
			end else begin
				v[k] = trav_pkg::coord_t'($signed(r[9:0]));
			end
		end
		write_ray(id, v[0], v[1], v[2], v[3], v[4], v[5]);
	endtask

	// holds the payload until accepted and then queues the expected result
	task automatic send_request(input trav_pkg::ray_id_t id, input trav_pkg::node_id_t node,
		input trav_pkg::axis_t axis, input trav_pkg::coord_t split,
		input trav_pkg::tparam_t t_min, input trav_pkg::tparam_t t_max);
		trav_pkg::visit_t visit;
		trav_pkg::node_id_t near_id;
		trav_pkg::node_id_t far_id;
		trav_pkg::tparam_t t_split;
		@(negedge clk);
		update_stall();
		req_valid = 1'b1;
		{req_ray_id, req_node_id, req_axis} = {id, node, axis};
		{req_split, req_t_min, req_t_max} = {split, t_min, t_max};
		@(posedge clk);
		while (req_stall) begin
			@(negedge clk);
			update_stall();
			@(posedge clk);
		end
		predict(id, node, axis, split, t_min, t_max, visit, near_id, far_id, t_split);
		u_checker.expect_result(id, visit, near_id, far_id, t_split, cycle);
		sent_count++;
	endtask

	task automatic send_random_request(input trav_pkg::axis_t axis);
		logic [31:0] r1;
		logic [31:0] r2;
		trav_pkg::tparam_t t_min;
		r1 = next_rand();
		r2 = next_rand();
		t_min = trav_pkg::tparam_t'($signed(r2[11:0]));
		// one split in four spans the full range
		send_request(trav_pkg::ray_id_t'(r1), trav_pkg::node_id_t'(r1 >> 4), axis,
			(r1[13:12] == 2'd0) ? r1[31:16] : trav_pkg::coord_t'($signed(r1[27:16])),
			t_min, t_min + trav_pkg::tparam_t'(r2[27:16]));
	endtask

	task automatic drain();
		@(negedge clk);
		req_valid = 1'b0;
		stall_mode = 1'b0;
		out_stall = 1'b0;
		while (result_count != sent_count) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic report_test(input string name);
		$display("test %s finished, %0d requests, %0d errors so far", name, sent_count,
			tb_errors + error_count);
	endtask

	initial begin
		rng_state = 32'h0f84_8c6e;
		{rst_n, ray_we, req_valid, out_stall, stall_mode, check_latency} = '0;
		{ray_waddr, ray_origin_x, ray_origin_y, ray_origin_z} = '0;
		{ray_inv_dir_x, ray_inv_dir_y, ray_inv_dir_z} = '0;
		{req_ray_id, req_node_id, req_axis, req_split, req_t_min, req_t_max} = '0;
		{stall_left, sent_count, tb_errors} = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		@(negedge clk);
		if (out_valid !== 1'b0 || req_stall !== 1'b0) begin
			$display("CHECK FAILED out_valid req_stall expected 0 0 got %h %h", out_valid,
				req_stall);
			tb_errors++;
		end
		report_test("reset_idle");

		for (int i = 0; i < `NUM_RAYS; i++) begin
			write_random_ray(trav_pkg::ray_id_t'(i));
		end
		// node ff checks the sibling id wrap
		for (int i = 0; i < `NUM_RAYS; i++) begin
			send_request(trav_pkg::ray_id_t'(i),
				(i == 15) ? 8'hff : trav_pkg::node_id_t'(next_rand()),
				trav_pkg::axis_t'(`AXIS_LEAF), trav_pkg::coord_t'(next_rand()),
				16'sd0, 16'sd100);
		end
		drain();
		report_test("leaf_nodes");

		for (int i = 0; i < 200; i++) begin
			send_random_request(trav_pkg::axis_t'(i % 3));
		end
		drain();
		// x gives t_split 768 at split 3.0 while y and z saturate
		write_ray(0, 16'sd0, -16'sd32768, -16'sd32768, 16'sd256, 16'sd32767, -16'sd32768);
		send_request(0, 8'h10, 2'd0, 16'sh0300, 16'sd768, 16'sd2000);
		send_request(0, 8'h10, 2'd0, 16'sh0300, 16'sd0, 16'sd768);
		send_request(0, 8'h10, 2'd0, 16'sh0300, 16'sd767, 16'sd769);
		send_request(0, 8'h10, 2'd0, -16'sd256, 16'sd0, 16'sd100);
		send_request(0, 8'h11, 2'd1, 16'sh7fff, 16'sd0, 16'sh7fff);
		send_request(0, 8'h12, 2'd2, 16'sh7fff, 16'sd0, 16'sd100);
		drain();
		report_test("split_and_visit");

		stall_mode = 1'b1;
		for (int i = 0; i < 150; i++) begin
			send_random_request(trav_pkg::axis_t'(i % 3));
		end
		drain();
		check_latency = 1'b1;
		for (int i = 0; i < 20; i++) begin
			send_random_request(trav_pkg::axis_t'(i % 3));
			drain();
		end
		check_latency = 1'b0;
		report_test("backpressure_latency");

		for (int pass = 0; pass < 2; pass++) begin
			write_random_ray(trav_pkg::ray_id_t'(5));
			for (int a = 0; a < 3; a++) begin
				send_request(5, 8'h20, trav_pkg::axis_t'(a), 16'sh0040, -16'sd512, 16'sd2048);
			end
			drain();
		end
		report_test("ray_rewrite");

		$display("requests %0d results %0d errors %0d", sent_count, result_count,
			tb_errors + error_count);
		if (tb_errors + error_count == 0 && result_count == sent_count) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/trav_pkg.sv
verilog/trav_if.sv
verilog/trav_decode.sv
verilog/trav_execute.sv
verilog/trav_result.sv
verilog/raypipe_trav.sv
dv/trav_checker.sv
dv/tb_raypipe_trav.sv
